// File: hw/ifu_pkg.sv
// shared definitions of the instruction fetch stage
// widths with a meaning, address source encodings and fixed entry points
package ifu_pkg;

  // byte address in the instruction space
  typedef logic [31:0] addr_t;
  // instruction word, raw or expanded
  typedef logic [31:0] instr_t;
  // one 16-bit parcel of the instruction stream
  typedef logic [15:0] half_t;
  // interrupt cause, picks the vectored entry
  typedef logic [4:0]  irq_cause_t;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // kind of trap target
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  ////////////////////
  // entry points
  ////////////////////

  // debug module halt and exception entries
  localparam addr_t DM_HALT_ADDR = 32'h1A110800;
  localparam addr_t DM_EXC_ADDR  = 32'h1A110808;

  // boot entry offset inside the 256-byte aligned boot region
  localparam logic [7:0] BOOT_OFFSET = 8'h80;

  // low mtvec bits that the trap logic ignores
  localparam int unsigned MTVEC_ALIGN_W = 8;

endpackage

// File: hw/pc_select.sv
`timescale 1ns/1ps

// next fetch address selection
// picks boot, jump, trap, return or debug target, strobes mtvec init on boot
module pc_select (
  input  ifu_pkg::pc_sel_e     pc_mux_i,
  input  ifu_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  ifu_pkg::irq_cause_t  irq_cause_i,
  input  ifu_pkg::addr_t       boot_addr_i,
  input  ifu_pkg::addr_t       branch_target_i,
  input  ifu_pkg::addr_t       csr_mtvec_i,
  input  ifu_pkg::addr_t       csr_mepc_i,
  input  ifu_pkg::addr_t       csr_depc_i,
  input  logic                 pc_set_i,
  output ifu_pkg::addr_t       fetch_addr_n_o,
  output logic                 csr_mtvec_init_o
);

  import ifu_pkg::*;

  addr_t exc_pc;
  addr_t mtvec_base;
  addr_t boot_pc;

  // trap base, low bits forced to zero
  assign mtvec_base = {csr_mtvec_i[31:MTVEC_ALIGN_W], {MTVEC_ALIGN_W{1'b0}}};

  // boot region is 256-byte aligned
  assign boot_pc = {boot_addr_i[31:8], BOOT_OFFSET};

  ////////////////////
  // trap target
  ////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored mode, one word per cause
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:MTVEC_ALIGN_W], 1'b0, irq_cause_i, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  ////////////////////
  // fetch address
  ////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap or from debug mode
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // CSR file loads its mtvec reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

// instruction fetch unit with a one-word buffer
// fetches aligned words over the req/gnt/rvalid bus, one request at a time,
// and realigns 16-bit parcels into whole instructions
module fetch_unit (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            branch_i,
  input  ifu_pkg::addr_t  branch_addr_i,
  input  logic            ready_i,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  ifu_pkg::instr_t instr_rdata_i,
  input  logic            instr_bus_err_i,
  output logic            instr_req_o,
  output ifu_pkg::addr_t  instr_addr_o,
  output logic            valid_o,
  output ifu_pkg::instr_t rdata_o,
  output ifu_pkg::addr_t  addr_o,
  output logic            err_o,
  output logic            err_plus2_o,
  output logic            busy_o
);

  import ifu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } fetch_state_e;

  fetch_state_e state_q, state_d;
  // response in flight belongs to a squashed fetch
  logic         discard_q, discard_d;

  // word buffer
  instr_t word_q;
  logic   word_err_q;
  logic   word_valid_q, word_valid_d;

  // high parcel left over from the previous word
  half_t  half_q;
  logic   half_err_q;
  logic   half_valid_q, half_valid_d;

  // current instruction address, bit 1 selects the parcel
  addr_t  addr_q, addr_d;
  addr_t  req_addr_q;
  addr_t  next_waddr_q;
  addr_t  branch_waddr;
  addr_t  start_addr;

  half_t  parcel;
  logic   is_c;
  logic   fill;
  logic   to_half;
  logic   start;

  ////////////////////
  // output parcel
  ////////////////////

  assign parcel = half_valid_q ? half_q : (addr_q[1] ? word_q[31:16] : word_q[15:0]);
  assign is_c   = (parcel[1:0] != 2'b11);

  // a full-size instruction in the high half needs the next word first
  assign valid_o = word_valid_q & (half_valid_q | ~addr_q[1] | is_c);
  assign rdata_o = half_valid_q ? {word_q[15:0], half_q} :
                   (addr_q[1] ? {16'h0000, word_q[31:16]} : word_q);
  assign addr_o  = addr_q;

  // error of the word holding the first parcel
  assign err_o       = half_valid_q ? half_err_q : word_err_q;
  // only the second word failed
  assign err_plus2_o = half_valid_q & ~half_err_q & word_err_q;

  ////////////////////
  // buffer control
  ////////////////////

  assign fill = (state_q == WAIT_RVALID) & instr_rvalid_i & ~discard_q;

  always_comb begin
    word_valid_d = word_valid_q;
    half_valid_d = half_valid_q;
    addr_d       = addr_q;
    to_half      = 1'b0;
    if (branch_i) begin
      // redirect drops every buffered parcel
      word_valid_d = 1'b0;
      half_valid_d = 1'b0;
      addr_d       = {branch_addr_i[31:1], 1'b0};
    end else begin
      if (valid_o && ready_i) begin
        addr_d       = addr_q + (is_c ? 32'd2 : 32'd4);
        half_valid_d = 1'b0;
        // word is used up unless its high parcel is still pending
        if (!half_valid_q && (addr_q[1] || !is_c)) begin
          word_valid_d = 1'b0;
        end
      end else if (word_valid_q && !half_valid_q && addr_q[1] && !is_c) begin
        // park the low half of a straddling instruction
        to_half      = 1'b1;
        half_valid_d = 1'b1;
        word_valid_d = 1'b0;
      end
      if (fill) begin
        word_valid_d = 1'b1;
      end
    end
  end

  ////////////////////
  // bus FSM
  ////////////////////

  assign branch_waddr = {branch_addr_i[31:2], 2'b00};
  assign start_addr   = branch_i ? branch_waddr : next_waddr_q;
  // new word only once the buffer runs empty
  assign start        = (state_q == IDLE) & req_i & ~word_valid_d;

  always_comb begin
    state_d   = state_q;
    discard_d = discard_q;
    case (state_q)
      IDLE: begin
        if (start) begin
          state_d = WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d   = IDLE;
          discard_d = 1'b0;
        end
      end
      default: state_d = IDLE;
    endcase
    // redirect while a request is open, its response gets dropped
    if (branch_i && (state_q != IDLE) && !((state_q == WAIT_RVALID) && instr_rvalid_i)) begin
      discard_d = 1'b1;
    end
  end

  assign instr_req_o  = (state_q == WAIT_GNT);
  assign instr_addr_o = req_addr_q;
  assign busy_o       = (state_q != IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      discard_q    <= 1'b0;
      word_valid_q <= 1'b0;
      half_valid_q <= 1'b0;
      addr_q       <= '0;
      req_addr_q   <= '0;
      next_waddr_q <= '0;
      word_q       <= '0;
      word_err_q   <= 1'b0;
      half_q       <= '0;
      half_err_q   <= 1'b0;
    end else begin
      state_q      <= state_d;
      discard_q    <= discard_d;
      word_valid_q <= word_valid_d;
      half_valid_q <= half_valid_d;
      addr_q       <= addr_d;
      // address stays put on the bus until granted
      if (start) begin
        req_addr_q   <= start_addr;
        next_waddr_q <= start_addr + 32'd4;
      end else if (branch_i) begin
        next_waddr_q <= branch_waddr;
      end
      if (fill) begin
        word_q     <= instr_rdata_i;
        word_err_q <= instr_bus_err_i;
      end
      if (to_half) begin
        half_q     <= word_q[31:16];
        half_err_q <= word_err_q;
      end
    end
  end

endmodule

// File: hw/compressed_expander.sv
`timescale 1ns/1ps

// compressed instruction expander
// turns C.ADDI, C.LI, C.MV and C.ADD into 32-bit forms, flags other
// compressed encodings as illegal
module compressed_expander (
  input  ifu_pkg::instr_t instr_i,
  output ifu_pkg::instr_t instr_o,
  output logic            is_compressed_o,
  output logic            illegal_o
);

  import ifu_pkg::*;

  half_t       parcel;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm;

  assign parcel = instr_i[15:0];
  assign rd     = parcel[11:7];
  assign rs2    = parcel[6:2];

  // CI immediate, sign extended to 12 bits
  assign imm = {{6{parcel[12]}}, parcel[12], parcel[6:2]};

  // full-size instructions end in 2'b11
  assign is_compressed_o = (parcel[1:0] != 2'b11);

  always_comb begin
    // unsupported parcels go out zero extended
    instr_o   = {16'h0000, parcel};
    illegal_o = 1'b0;
    if (!is_compressed_o) begin
      instr_o = instr_i;
    end else begin
      // funct3 and quadrant
      case ({parcel[15:13], parcel[1:0]})
        5'b000_01: begin
          // c.addi, also c.nop -> addi rd, rd, imm
          instr_o = {imm, rd, 3'b000, rd, 7'b0010011};
        end
        5'b010_01: begin
          // c.li -> addi rd, x0, imm
          instr_o = {imm, 5'd0, 3'b000, rd, 7'b0010011};
        end
        5'b100_10: begin
          if (rs2 == 5'd0) begin
            // c.jr, c.jalr and c.ebreak not supported
            illegal_o = 1'b1;
          end else if (parcel[12]) begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'b0000000, rs2, rd, 3'b000, rd, 7'b0110011};
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0000000, rs2, 5'd0, 3'b000, rd, 7'b0110011};
          end
        end
        default: begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: hw/if_id_register.sv
`timescale 1ns/1ps

// IF-ID pipeline register
// hands the fetched instruction to decode with its valid and new flags
module if_id_register (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            if_valid_i,
  input  logic            id_in_ready_i,
  input  logic            pc_set_i,
  input  logic            instr_valid_clear_i,
  input  ifu_pkg::instr_t instr_i,
  input  ifu_pkg::half_t  instr_c_i,
  input  logic            is_compressed_i,
  input  logic            illegal_c_i,
  input  logic            err_i,
  input  logic            err_plus2_i,
  input  ifu_pkg::addr_t  pc_if_i,
  output logic            fetch_ready_o,
  output logic            instr_valid_id_o,
  output logic            instr_new_id_o,
  output ifu_pkg::instr_t instr_rdata_id_o,
  output ifu_pkg::instr_t instr_rdata_alu_id_o,
  output ifu_pkg::half_t  instr_rdata_c_id_o,
  output logic            instr_is_compressed_id_o,
  output logic            illegal_c_insn_id_o,
  output logic            instr_fetch_err_o,
  output logic            instr_fetch_err_plus2_o,
  output ifu_pkg::addr_t  pc_id_o
);

  logic take;

  assign fetch_ready_o = id_in_ready_i;

  // a redirect in the same cycle squashes the instruction
  assign take = if_valid_i & id_in_ready_i & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      // valid holds until decode is done with it
      instr_valid_id_o <= take | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= take;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o         <= '0;
      instr_rdata_alu_id_o     <= '0;
      instr_rdata_c_id_o       <= '0;
      instr_is_compressed_id_o <= 1'b0;
      illegal_c_insn_id_o      <= 1'b0;
      instr_fetch_err_o        <= 1'b0;
      instr_fetch_err_plus2_o  <= 1'b0;
      pc_id_o                  <= '0;
    end else if (take) begin
      instr_rdata_id_o         <= instr_i;
      // second copy feeds the ALU operand path, less fan-out
      instr_rdata_alu_id_o     <= instr_i;
      instr_rdata_c_id_o       <= instr_c_i;
      instr_is_compressed_id_o <= is_compressed_i;
      illegal_c_insn_id_o      <= illegal_c_i;
      instr_fetch_err_o        <= err_i;
      instr_fetch_err_plus2_o  <= err_plus2_i;
      pc_id_o                  <= pc_if_i;
    end
  end

endmodule

// File: hw/if_stage.sv
`timescale 1ns/1ps

// instruction fetch stage top level
// address select, bus fetch, compressed expansion and the IF-ID register
module if_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  // instruction bus
  output logic                 instr_req_o,
  output ifu_pkg::addr_t       instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  ifu_pkg::instr_t      instr_rdata_i,
  input  logic                 instr_bus_err_i,
  // redirect control
  input  logic                 pc_set_i,
  input  ifu_pkg::pc_sel_e     pc_mux_i,
  input  ifu_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  ifu_pkg::irq_cause_t  irq_cause_i,
  input  ifu_pkg::addr_t       boot_addr_i,
  input  ifu_pkg::addr_t       branch_target_i,
  input  ifu_pkg::addr_t       csr_mtvec_i,
  input  ifu_pkg::addr_t       csr_mepc_i,
  input  ifu_pkg::addr_t       csr_depc_i,
  // decode handshake
  input  logic                 instr_valid_clear_i,
  input  logic                 id_in_ready_i,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output ifu_pkg::instr_t      instr_rdata_id_o,
  output ifu_pkg::instr_t      instr_rdata_alu_id_o,
  output ifu_pkg::half_t       instr_rdata_c_id_o,
  output logic                 instr_is_compressed_id_o,
  output logic                 illegal_c_insn_id_o,
  output logic                 instr_fetch_err_o,
  output logic                 instr_fetch_err_plus2_o,
  output ifu_pkg::addr_t       pc_id_o,
  output ifu_pkg::addr_t       pc_if_o,
  output logic                 csr_mtvec_init_o,
  output logic                 if_busy_o
);

  import ifu_pkg::*;

  addr_t  fetch_addr_n;
  logic   fetch_valid;
  logic   fetch_ready;
  instr_t fetch_rdata;
  logic   fetch_err;
  logic   fetch_err_plus2;
  instr_t instr_expanded;
  logic   instr_is_compressed;
  logic   illegal_c_insn;

  pc_select pc_select_inst (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_cause_i      (irq_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .pc_set_i         (pc_set_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // the redirect strobe doubles as the fetch branch request
  fetch_unit fetch_unit_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (fetch_addr_n),
    .ready_i         (fetch_ready),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .valid_o         (fetch_valid),
    .rdata_o         (fetch_rdata),
    .addr_o          (pc_if_o),
    .err_o           (fetch_err),
    .err_plus2_o     (fetch_err_plus2),
    .busy_o          (if_busy_o)
  );

  compressed_expander compressed_expander_inst (
    .instr_i         (fetch_rdata),
    .instr_o         (instr_expanded),
    .is_compressed_o (instr_is_compressed),
    .illegal_o       (illegal_c_insn)
  );

  // raw parcel kept for mtval
  if_id_register if_id_register_inst (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .if_valid_i               (fetch_valid),
    .id_in_ready_i            (id_in_ready_i),
    .pc_set_i                 (pc_set_i),
    .instr_valid_clear_i      (instr_valid_clear_i),
    .instr_i                  (instr_expanded),
    .instr_c_i                (fetch_rdata[15:0]),
    .is_compressed_i          (instr_is_compressed),
    .illegal_c_i              (illegal_c_insn),
    .err_i                    (fetch_err),
    .err_plus2_i              (fetch_err_plus2),
    .pc_if_i                  (pc_if_o),
    .fetch_ready_o            (fetch_ready),
    .instr_valid_id_o         (instr_valid_id_o),
    .instr_new_id_o           (instr_new_id_o),
    .instr_rdata_id_o         (instr_rdata_id_o),
    .instr_rdata_alu_id_o     (instr_rdata_alu_id_o),
    .instr_rdata_c_id_o       (instr_rdata_c_id_o),
    .instr_is_compressed_id_o (instr_is_compressed_id_o),
    .illegal_c_insn_id_o      (illegal_c_insn_id_o),
    .instr_fetch_err_o        (instr_fetch_err_o),
    .instr_fetch_err_plus2_o  (instr_fetch_err_plus2_o),
    .pc_id_o                  (pc_id_o)
  );

endmodule

// File: verification/if_stage_tests.svh
// directed tests and reference rules of the fetch stage testbench
// included into the testbench module

////////////////////
// reference rules
////////////////////

function automatic instr_t word_at(input addr_t a);
  addr_t w;
  w = {a[31:2], 2'b00};
  // unset words hold a 32-bit filler built from the address
  if (prog.exists(w)) begin
    return prog[w];
  end
  return {w[31:2], 2'b11};
endfunction

function automatic bit has_err(input addr_t a);
  return err_map.exists({a[31:2], 2'b00});
endfunction

function automatic half_t parcel_at(input addr_t a);
  instr_t w;
  w = word_at(a);
  return a[1] ? w[31:16] : w[15:0];
endfunction

function automatic addr_t expected_boot(input addr_t boot);
  return (boot & 32'hFFFF_FF00) | 32'h80;
endfunction

function automatic addr_t expected_vector(input exc_pc_sel_e kind, input addr_t mtvec,
                                          input int cause);
  case (kind)
    EXC_PC_IRQ:     return (mtvec & 32'hFFFF_FF00) + 32'(cause * 4);
    EXC_PC_DBD:     return 32'h1A11_0800;
    EXC_PC_DBG_EXC: return 32'h1A11_0808;
    default:        return mtvec & 32'hFFFF_FF00;
  endcase
endfunction

function automatic instr_t expand_parcel(input half_t p, output logic illegal);
  logic [11:0] imm;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  imm     = {{7{p[12]}}, p[6:2]};
  rd      = p[11:7];
  rs2     = p[6:2];
  illegal = 1'b0;
  if (p[1:0] == 2'b01 && p[15:13] == 3'd0) begin
    return {imm, rd, 3'd0, rd, 7'h13};
  end else if (p[1:0] == 2'b01 && p[15:13] == 3'd2) begin
    return {imm, 5'd0, 3'd0, rd, 7'h13};
  end else if (p[1:0] == 2'b10 && p[15:13] == 3'd4 && rs2 != 5'd0) begin
    return {7'd0, rs2, (p[12] ? rd : 5'd0), 3'd0, rd, 7'h33};
  end
  illegal = 1'b1;
  return {16'h0000, p};
endfunction

////////////////////
// helpers
////////////////////

task automatic fail_value(input string test, input string what, input logic [31:0] exp,
                          input logic [31:0] act);
  errors++;
  $display("Error: %s %s expected %h actual %h", test, what, exp, act);
  $display("Testbench failed");
  $fatal(1);
endtask

task automatic check_value(input string test, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
  assert (exp === act) else fail_value(test, what, exp, act);
endtask

// one-cycle redirect, mtvec init only on boot
task automatic redirect_to(input pc_sel_e sel, input exc_pc_sel_e kind);
  @(posedge clk_i);
  pc_set_i     <= 1'b1;
  pc_mux_i     <= sel;
  exc_pc_mux_i <= kind;
  req_i        <= 1'b1;
  @(posedge clk_i);
  check_value("redirect", "mtvec init", 32'(sel == PC_BOOT), 32'(csr_mtvec_init_o));
  pc_set_i <= 1'b0;
endtask

task automatic wait_new_instr();
  do @(posedge clk_i); while (!instr_new_id_o);
endtask

// walks the program from start_pc and compares every decoded instruction
task automatic check_stream(input string test, input addr_t start_pc, input int count);
  addr_t  pc;
  addr_t  next_pc;
  half_t  lo;
  instr_t raw;
  instr_t exp;
  logic   c;
  logic   ill;
  logic   e1;
  pc = start_pc;
  repeat (count) begin
    wait_new_instr();
    lo  = parcel_at(pc);
    c   = (lo[1:0] != 2'b11);
    raw = {parcel_at(pc + 2), lo};
    ill = 1'b0;
    exp = raw;
    if (c) begin
      exp = expand_parcel(lo, ill);
    end
    e1      = has_err(pc);
    next_pc = pc + (c ? 32'd2 : 32'd4);
    check_value(test, "valid", 1, 32'(instr_valid_id_o));
    check_value(test, "pc", pc, pc_id_o);
    check_value(test, "instr", exp, instr_rdata_id_o);
    check_value(test, "alu instr", exp, instr_rdata_alu_id_o);
    check_value(test, "raw parcel", 32'(lo), 32'(instr_rdata_c_id_o));
    check_value(test, "compressed", 32'(c), 32'(instr_is_compressed_id_o));
    check_value(test, "illegal", 32'(ill), 32'(illegal_c_insn_id_o));
    check_value(test, "fetch err", 32'(e1), 32'(instr_fetch_err_o));
    check_value(test, "fetch err plus2", 32'(!c && pc[1] && !e1 && has_err(pc + 2)),
                32'(instr_fetch_err_plus2_o));
    // fetch side has already moved on to the following instruction
    check_value(test, "fetch pc", next_pc, pc_if_o);
    pc = next_pc;
  end
endtask

////////////////////
// tests
////////////////////

task automatic boot_sequential_fetch();
  // fetch stage idle straight out of reset
  check_value("reset", "idle outputs", 0,
              32'({instr_req_o, instr_valid_id_o, instr_new_id_o, instr_fetch_err_o,
                   csr_mtvec_init_o, if_busy_o}));
  prog[32'h1280] = 32'h0010_0093;
  prog[32'h1284] = 32'h0020_8113;
  prog[32'h1288] = 32'h0020_81B3;
  prog[32'h128C] = 32'h4011_0233;
  boot_addr_i <= 32'h0000_1234;
  redirect_to(PC_BOOT, EXC_PC_EXC);
  check_stream("boot", expected_boot(32'h0000_1234), 6);
endtask

task automatic mixed_length_stream();
  // c.li, c.addi, addi, c.mv, straddling add, c.add, c.lw, c.nop, addi
  prog[32'h1800] = 32'h0085_52F5;
  prog[32'h1804] = 32'h00A0_0513;
  prog[32'h1808] = 32'h81B3_852E;
  prog[32'h180C] = 32'h9192_0020;
  prog[32'h1810] = 32'h0001_4108;
  prog[32'h1814] = 32'h0000_0013;
  branch_target_i <= 32'h0000_1800;
  redirect_to(PC_JUMP, EXC_PC_EXC);
  check_stream("mixed", 32'h1800, 9);
endtask

task automatic redirect_sources();
  int causes [3] = '{0, 7, 31};
  branch_target_i <= 32'h0000_2002;
  redirect_to(PC_JUMP, EXC_PC_EXC);
  check_stream("jump", 32'h2002, 3);
  csr_mtvec_i <= 32'h0000_3055;
  redirect_to(PC_EXC, EXC_PC_EXC);
  check_stream("exception", expected_vector(EXC_PC_EXC, 32'h3055, 0), 3);
  foreach (causes[i]) begin
    irq_cause_i <= irq_cause_t'(causes[i]);
    redirect_to(PC_EXC, EXC_PC_IRQ);
    check_stream("irq", expected_vector(EXC_PC_IRQ, 32'h3055, causes[i]), 2);
  end
  redirect_to(PC_EXC, EXC_PC_DBD);
  check_stream("debug halt", expected_vector(EXC_PC_DBD, 32'h3055, 0), 2);
  redirect_to(PC_EXC, EXC_PC_DBG_EXC);
  check_stream("debug exc", expected_vector(EXC_PC_DBG_EXC, 32'h3055, 0), 2);
  csr_mepc_i <= 32'h0000_3104;
  redirect_to(PC_ERET, EXC_PC_EXC);
  check_stream("mret", 32'h3104, 2);
  csr_depc_i <= 32'h0000_3206;
  redirect_to(PC_DRET, EXC_PC_EXC);
  check_stream("dret", 32'h3206, 2);
endtask

task automatic bus_error_flags();
  // errored addi, c.nop, straddle into errored word, c.nop in that word
  prog[32'h2800]    = 32'h0010_0093;
  prog[32'h2804]    = 32'h8113_0001;
  prog[32'h2808]    = 32'h0001_0020;
  prog[32'h280C]    = 32'h0000_0013;
  err_map[32'h2800] = 1'b1;
  err_map[32'h2808] = 1'b1;
  branch_target_i <= 32'h0000_2800;
  redirect_to(PC_JUMP, EXC_PC_EXC);
  check_stream("bus error", 32'h2800, 5);
endtask

task automatic backpressure_handling();
  ready_mode = 1;
  branch_target_i <= 32'h0000_1800;
  redirect_to(PC_JUMP, EXC_PC_EXC);
  check_stream("backpressure", 32'h1800, 12);
  // decode stalls, the last instruction must stay valid until cleared
  ready_mode = 2;
  repeat (4) @(posedge clk_i);
  check_value("valid hold", "valid", 1, 32'(instr_valid_id_o));
  instr_valid_clear_i <= 1'b1;
  @(posedge clk_i);
  instr_valid_clear_i <= 1'b0;
  @(posedge clk_i);
  check_value("valid clear", "valid", 0, 32'(instr_valid_id_o));
endtask

// File: verification/if_stage_tb.sv
`timescale 1ns/1ps

// testbench for the instruction fetch stage
// clock, reset, bus memory model, decode ready driver, watchdog, reference rules
module if_stage_tb;

  import ifu_pkg::*;

  // total checked instructions over all tests, sets the watchdog budget
  localparam int INSTR_TOTAL     = 52;
  localparam int WATCHDOG_CYCLES = INSTR_TOTAL * 20;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        instr_bus_err_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_cause_t  irq_cause_i;
  addr_t       boot_addr_i;
  addr_t       branch_target_i;
  addr_t       csr_mtvec_i;
  addr_t       csr_mepc_i;
  addr_t       csr_depc_i;
  logic        instr_valid_clear_i;
  logic        id_in_ready_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  instr_t      instr_rdata_id_o;
  instr_t      instr_rdata_alu_id_o;
  half_t       instr_rdata_c_id_o;
  logic        instr_is_compressed_id_o;
  logic        illegal_c_insn_id_o;
  logic        instr_fetch_err_o;
  logic        instr_fetch_err_plus2_o;
  addr_t       pc_id_o;
  addr_t       pc_if_o;
  logic        csr_mtvec_init_o;
  logic        if_busy_o;

  // program memory by word address, plus words that answer with a bus error
  instr_t prog [addr_t];
  bit     err_map [addr_t];
  // 0 ready high, 1 random ready, 2 ready low
  int     ready_mode;
  int     errors;

  if_stage if_stage_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  `include "if_stage_tests.svh"

  ////////////////////
  // bus model
  ////////////////////

  initial begin
    int    delay;
    addr_t addr;
    forever begin
      @(posedge clk_i);
      // outside a transfer busy follows the request line
      check_value("bus", "busy", 32'(instr_req_o), 32'(if_busy_o));
      if (instr_req_o) begin
        addr = instr_addr_o;
        check_value("bus", "word aligned addr", 0, 32'(addr[1:0]));
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk_i);
          // request and address stay put until the grant
          check_value("bus", "req held", 1, 32'(instr_req_o));
          check_value("bus", "addr held", addr, instr_addr_o);
        end
        instr_gnt_i <= 1'b1;
        @(posedge clk_i);
        instr_gnt_i <= 1'b0;
        delay = $urandom_range(2, 0);
        repeat (delay) @(posedge clk_i);
        check_value("bus", "busy", 1, 32'(if_busy_o));
        instr_rvalid_i  <= 1'b1;
        instr_rdata_i   <= word_at(addr);
        instr_bus_err_i <= has_err(addr);
        @(posedge clk_i);
        instr_rvalid_i  <= 1'b0;
        instr_bus_err_i <= 1'b0;
      end
    end
  end

  // decode side ready
  always @(posedge clk_i) begin
    case (ready_mode)
      0:       id_in_ready_i <= 1'b1;
      1:       id_in_ready_i <= ($urandom_range(1, 0) == 1);
      default: id_in_ready_i <= 1'b0;
    endcase
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout, the fetch stage stopped delivering instructions");
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'h47df));
    errors              = 0;
    ready_mode          = 0;
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    irq_cause_i         = '0;
    boot_addr_i         = '0;
    branch_target_i     = '0;
    csr_mtvec_i         = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    boot_sequential_fetch();
    mixed_length_stream();
    redirect_sources();
    bus_error_flags();
    backpressure_handling();
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: ifu.f
hw/ifu_pkg.sv
hw/pc_select.sv
hw/fetch_unit.sv
hw/compressed_expander.sv
hw/if_id_register.sv
hw/if_stage.sv
+incdir+verification
verification/if_stage_tb.sv
